//--- verilog/rv32i_bus_consts.svh
`ifndef RV32I_BUS_CONSTS_SVH
`define RV32I_BUS_CONSTS_SVH

// processor side
`define RV_XLEN 32
`define RV_ADDR_W 32
`define RV_MASK_W 4

// axi side
`define RV_BUS_W 64
`define RV_STRB_W 8
`define RV_RESP_W 2

`define RV_RESP_OKAY 2'b00

// picks the upper 32-bit lane of a beat
`define RV_LANE_BIT 2

`endif

//--- verilog/rv32i_bus_pkg.sv
`include "rv32i_bus_consts.svh"

package rv32i_bus_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_ADDR_W-1:0] addr_t;
  typedef logic [`RV_BUS_W-1:0] bus_data_t;
  typedef logic [`RV_STRB_W-1:0] bus_strb_t;
  typedef logic [`RV_MASK_W-1:0] word_mask_t;
  typedef logic [`RV_RESP_W-1:0] axi_resp_t;

  // one single-beat transaction at a time
  typedef enum logic [2:0] {
    st_idle,
    st_raddr,
    st_rdata,
    st_write,
    st_wresp
  } axi_state_t;

  // who owns the engine
  typedef enum logic {
    sel_fetch,
    sel_data
  } port_sel_t;

endpackage

//--- verilog/bus_req_if.sv
`timescale 1ns/1ps

interface bus_req_if;
  import rv32i_bus_pkg::*;

  // request, held until accept
  logic pending;
  logic write;
  addr_t addr;
  bus_data_t wdata;
  bus_strb_t strb;

  // response
  logic accept;
  logic done;
  bus_data_t rdata;
  logic err;

  modport client (
    output pending, write, addr, wdata, strb,
    input accept, done, rdata, err
  );

  modport server (
    input pending, write, addr, wdata, strb,
    output accept, done, rdata, err
  );

endinterface

//--- verilog/bus_port.sv
`timescale 1ns/1ps
`include "rv32i_bus_consts.svh"

module bus_port #(
  parameter int can_write = 1
) (
  input logic clock,
  input logic reset,
  input logic req,
  input logic we,
  input rv32i_bus_pkg::addr_t addr,
  input rv32i_bus_pkg::word_t wdata,
  input rv32i_bus_pkg::word_mask_t mask,
  output rv32i_bus_pkg::word_t rdata,
  output logic err,
  output logic done,
  bus_req_if.client bus
);
  import rv32i_bus_pkg::*;

  logic pending_q;
  logic busy_q;
  logic write_q;
  logic lane_q;
  addr_t addr_q;
  bus_data_t wdata_q;
  bus_strb_t strb_q;
  logic write_en;
  logic lane;

  // fetch port never writes
  assign write_en = (can_write != 0) && we;
  assign lane = addr[`RV_LANE_BIT];

  always_ff @(posedge clock) begin
    if (reset) begin
      pending_q <= 1'b0;
      busy_q <= 1'b0;
    end else begin
      if (req) begin
        pending_q <= 1'b1;
      end else if (bus.accept) begin
        pending_q <= 1'b0;
      end
      if (req) begin
        busy_q <= 1'b1;
      end else if (bus.done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // request payload, placed on its lane
  always_ff @(posedge clock) begin
    if (req) begin
      addr_q <= addr;
      lane_q <= lane;
      write_q <= write_en;
      if (lane) begin
        wdata_q <= write_en ? {wdata, {`RV_XLEN{1'b0}}} : '0;
        strb_q <= write_en ? {mask, {`RV_MASK_W{1'b0}}} : '0;
      end else begin
        wdata_q <= write_en ? {{`RV_XLEN{1'b0}}, wdata} : '0;
        strb_q <= write_en ? {{`RV_MASK_W{1'b0}}, mask} : '0;
      end
    end
  end

  assign bus.pending = pending_q;
  assign bus.write = write_q;
  assign bus.addr = addr_q;
  assign bus.wdata = wdata_q;
  assign bus.strb = strb_q;

  // take back the matching half of the beat
  assign rdata = lane_q ? bus.rdata[`RV_BUS_W-1:`RV_XLEN] : bus.rdata[`RV_XLEN-1:0];
  assign err = bus.err;
  assign done = bus.done;

  // one request in flight per requester
  a_no_overlap: assert property (@(posedge clock) disable iff (reset)
    req |-> (!busy_q || bus.done))
    else $error("bus_port: new request before done");

endmodule

//--- verilog/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input logic clock,
  input logic reset,
  bus_req_if.server fetch,
  bus_req_if.server data,
  bus_req_if.client engine
);
  import rv32i_bus_pkg::*;

  logic in_flight;
  port_sel_t last_sel;
  port_sel_t choose;
  logic any_pending;

  assign any_pending = fetch.pending || data.pending;

  // round robin on a tie
  always_comb begin
    if (fetch.pending && data.pending) begin
      choose = (last_sel == sel_fetch) ? sel_data : sel_fetch;
    end else if (data.pending) begin
      choose = sel_data;
    end else begin
      choose = sel_fetch;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      in_flight <= 1'b0;
      last_sel <= sel_data;
    end else begin
      if (engine.accept) begin
        in_flight <= 1'b1;
        last_sel <= choose;
      end else if (engine.done) begin
        in_flight <= 1'b0;
      end
    end
  end

  // forward the chosen request while the engine is free
  assign engine.pending = !in_flight && any_pending;
  assign engine.write = (choose == sel_data) ? data.write : fetch.write;
  assign engine.addr = (choose == sel_data) ? data.addr : fetch.addr;
  assign engine.wdata = (choose == sel_data) ? data.wdata : fetch.wdata;
  assign engine.strb = (choose == sel_data) ? data.strb : fetch.strb;

  assign fetch.accept = engine.accept && (choose == sel_fetch);
  assign data.accept = engine.accept && (choose == sel_data);

  // response goes back to the owner only
  assign fetch.done = engine.done && (last_sel == sel_fetch);
  assign data.done = engine.done && (last_sel == sel_data);
  assign fetch.err = engine.err && (last_sel == sel_fetch);
  assign data.err = engine.err && (last_sel == sel_data);
  assign fetch.rdata = (last_sel == sel_fetch) ? engine.rdata : '0;
  assign data.rdata = (last_sel == sel_data) ? engine.rdata : '0;

  // accept reaches one port, and only a port that is waiting
  a_one_accept: assert property (@(posedge clock) disable iff (reset)
    !(fetch.accept && data.accept) &&
    (!fetch.accept || fetch.pending) && (!data.accept || data.pending))
    else $error("bus_arbiter: accept to both ports or to an idle port");

  // done only closes a transaction that was granted
  a_done_in_flight: assert property (@(posedge clock) disable iff (reset)
    engine.done |-> in_flight)
    else $error("bus_arbiter: done with nothing in flight");

endmodule

//--- verilog/axi_engine.sv
`timescale 1ns/1ps
`include "rv32i_bus_consts.svh"

module axi_engine (
  input logic clock,
  input logic reset,
  bus_req_if.server req,

  output logic awvalid,
  input logic awready,
  output logic [`RV_ADDR_W-1:0] awaddr,
  output logic wvalid,
  input logic wready,
  output logic [`RV_BUS_W-1:0] wdata,
  output logic [`RV_STRB_W-1:0] wstrb,
  input logic bvalid,
  output logic bready,
  input rv32i_bus_pkg::axi_resp_t bresp,

  output logic arvalid,
  input logic arready,
  output logic [`RV_ADDR_W-1:0] araddr,
  input logic rvalid,
  output logic rready,
  input rv32i_bus_pkg::bus_data_t rdata,
  input rv32i_bus_pkg::axi_resp_t rresp
);
  import rv32i_bus_pkg::*;

  axi_state_t state;
  logic aw_done;
  logic w_done;
  logic done_q;
  logic err_q;
  addr_t addr_q;
  bus_data_t wdata_q;
  bus_strb_t strb_q;
  bus_data_t rdata_q;
  logic accept;

  assign accept = (state == st_idle) && req.pending;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
      aw_done <= 1'b0;
      w_done <= 1'b0;
      done_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            state <= req.write ? st_write : st_raddr;
          end
        end
        st_raddr: begin
          if (arready) begin
            state <= st_rdata;
          end
        end
        st_rdata: begin
          if (rvalid) begin
            state <= st_idle;
            done_q <= 1'b1;
            err_q <= (rresp != `RV_RESP_OKAY);
          end
        end
        st_write: begin
          // aw and w may finish in either order
          if (awvalid && awready) begin
            aw_done <= 1'b1;
          end
          if (wvalid && wready) begin
            w_done <= 1'b1;
          end
          if ((aw_done || awready) && (w_done || wready)) begin
            state <= st_wresp;
            aw_done <= 1'b0;
            w_done <= 1'b0;
          end
        end
        st_wresp: begin
          if (bvalid) begin
            state <= st_idle;
            done_q <= 1'b1;
            err_q <= (bresp != `RV_RESP_OKAY);
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      addr_q <= req.addr;
      wdata_q <= req.wdata;
      strb_q <= req.strb;
    end
    if (rvalid && rready) begin
      rdata_q <= rdata;
    end
  end

  assign arvalid = (state == st_raddr);
  assign araddr = addr_q;
  assign rready = (state == st_rdata);
  assign awvalid = (state == st_write) && !aw_done;
  assign awaddr = addr_q;
  assign wvalid = (state == st_write) && !w_done;
  assign wdata = wdata_q;
  assign wstrb = strb_q;
  assign bready = (state == st_wresp);

  assign req.accept = accept;
  assign req.done = done_q;
  assign req.rdata = rdata_q;
  assign req.err = err_q;

  a_awaddr_stable: assert property (@(posedge clock) disable iff (reset)
    awvalid && !awready |=> $stable(awaddr))
    else $error("axi_engine: awaddr changed while waiting");

  a_araddr_stable: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> $stable(araddr))
    else $error("axi_engine: araddr changed while waiting");

endmodule

//--- verilog/rv32i_bus.sv
`timescale 1ns/1ps

module rv32i_bus (
  input logic clock,
  input logic reset,

  // instruction fetch
  input logic fetch_req,
  input rv32i_bus_pkg::addr_t fetch_addr,
  output rv32i_bus_pkg::word_t fetch_data,
  output logic fetch_err,
  output logic fetch_done,

  // load/store
  input logic data_req,
  input logic data_we,
  input rv32i_bus_pkg::addr_t data_addr,
  input rv32i_bus_pkg::word_t data_wdata,
  input rv32i_bus_pkg::word_mask_t data_mask,
  output rv32i_bus_pkg::word_t data_rdata,
  output logic data_err,
  output logic data_done,

  // axi master
  output logic awvalid,
  input logic awready,
  output rv32i_bus_pkg::addr_t awaddr,
  output logic wvalid,
  input logic wready,
  output rv32i_bus_pkg::bus_data_t wdata,
  output rv32i_bus_pkg::bus_strb_t wstrb,
  input logic bvalid,
  output logic bready,
  input rv32i_bus_pkg::axi_resp_t bresp,
  output logic arvalid,
  input logic arready,
  output rv32i_bus_pkg::addr_t araddr,
  input logic rvalid,
  output logic rready,
  input rv32i_bus_pkg::bus_data_t rdata,
  input rv32i_bus_pkg::axi_resp_t rresp
);

  bus_req_if fetch_bus ();
  bus_req_if data_bus ();
  bus_req_if engine_bus ();

  // fetch side has no write data
  bus_port #(.can_write(0)) i_fetch_port (
    .clock(clock),
    .reset(reset),
    .req(fetch_req),
    .we(1'b0),
    .addr(fetch_addr),
    .wdata('0),
    .mask('0),
    .rdata(fetch_data),
    .err(fetch_err),
    .done(fetch_done),
    .bus(fetch_bus.client)
  );

  bus_port #(.can_write(1)) i_data_port (
    .clock(clock),
    .reset(reset),
    .req(data_req),
    .we(data_we),
    .addr(data_addr),
    .wdata(data_wdata),
    .mask(data_mask),
    .rdata(data_rdata),
    .err(data_err),
    .done(data_done),
    .bus(data_bus.client)
  );

  bus_arbiter i_bus_arbiter (
    .clock(clock),
    .reset(reset),
    .fetch(fetch_bus.server),
    .data(data_bus.server),
    .engine(engine_bus.client)
  );

  axi_engine i_axi_engine (
    .clock(clock),
    .reset(reset),
    .req(engine_bus.server),
    .awvalid(awvalid),
    .awready(awready),
    .awaddr(awaddr),
    .wvalid(wvalid),
    .wready(wready),
    .wdata(wdata),
    .wstrb(wstrb),
    .bvalid(bvalid),
    .bready(bready),
    .bresp(bresp),
    .arvalid(arvalid),
    .arready(arready),
    .araddr(araddr),
    .rvalid(rvalid),
    .rready(rready),
    .rdata(rdata),
    .rresp(rresp)
  );

endmodule

//--- bench/tb_rv32i_bus.sv
`timescale 1ns/1ps
`include "rv32i_bus_consts.svh"

module tb_rv32i_bus;
  import rv32i_bus_pkg::*;

  localparam axi_resp_t resp_slverr = 2'b10;

  logic clock;
  logic reset;
  logic fetch_req;
  addr_t fetch_addr;
  word_t fetch_data;
  logic fetch_err;
  logic fetch_done;
  logic data_req;
  logic data_we;
  addr_t data_addr;
  word_t data_wdata;
  word_mask_t data_mask;
  word_t data_rdata;
  logic data_err;
  logic data_done;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  addr_t awaddr, araddr;
  bus_data_t wdata, rdata;
  bus_strb_t wstrb;
  axi_resp_t bresp, rresp;

  // vector columns
  int v_port[$];
  bit v_we[$];
  addr_t v_addr[$];
  word_t v_wdata[$];
  word_mask_t v_mask[$];
  bit v_pair[$];
  word_t v_rdata[$];
  bit v_err[$];

  // slave memory, one entry per 64-bit beat
  bus_data_t mem [bit [28:0]];
  logic [31:0] lfsr_state;
  int mismatches = 0;
  int failures = 0;
  int cycle_count;
  int cycle_limit = 100;

  rv32i_bus i_rv32i_bus (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int count, output int value);
    int k;
    value = 0;
    for (k = 0; k < count; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = (value << 1) | lfsr_state[0];
    end
  endtask

  // unwritten words read back their own address
  function automatic bus_data_t read_beat(input addr_t a);
    addr_t base;
    base = a & ~32'h7;
    if (mem.exists(a[31:3])) begin
      return mem[a[31:3]];
    end
    return {base | 32'h4, base};
  endfunction

  task automatic stall();
    int n;
    random_bits(2, n);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic take_aw(output addr_t a);
    stall();
    awready = 1'b1;
    @(posedge clock);
    a = awaddr;
    assert (awvalid) else begin
      failures++;
      $display("awvalid dropped before awready at %0t", $time);
    end
    #1 awready = 1'b0;
  endtask

  task automatic take_w(output bus_data_t d, output bus_strb_t s);
    stall();
    wready = 1'b1;
    @(posedge clock);
    d = wdata;
    s = wstrb;
    assert (wvalid) else begin
      failures++;
      $display("wvalid dropped before wready at %0t", $time);
    end
    #1 wready = 1'b0;
  endtask

  task automatic handle_read();
    addr_t a;
    stall();
    arready = 1'b1;
    @(posedge clock);
    a = araddr;
    assert (arvalid) else begin
      failures++;
      $display("arvalid dropped before arready at %0t", $time);
    end
    #1 arready = 1'b0;
    stall();
    rvalid = 1'b1;
    if (a[31]) begin
      rdata = '0;
      rresp = resp_slverr;
    end else begin
      rdata = read_beat(a);
      rresp = `RV_RESP_OKAY;
    end
    @(posedge clock);
    assert (rready) else begin
      failures++;
      $display("rready low while rvalid was offered at %0t", $time);
    end
    #1 rvalid = 1'b0;
    rdata = '0;
    rresp = `RV_RESP_OKAY;
  endtask

  task automatic handle_write();
    addr_t a;
    bus_data_t d;
    bus_strb_t s;
    bus_data_t beat;
    int w_first;
    int b;
    // either channel may finish first
    random_bits(1, w_first);
    if (w_first != 0) begin
      take_w(d, s);
      take_aw(a);
    end else begin
      take_aw(a);
      take_w(d, s);
    end
    assert (a[`RV_LANE_BIT] ? (s[3:0] == 4'h0) : (s[7:4] == 4'h0)) else begin
      mismatches++;
      $display("Mismatch at %0t: wstrb %h outside lane of awaddr %h", $time, s, a);
    end
    if (!a[31]) begin
      beat = read_beat(a);
      for (b = 0; b < 8; b++) begin
        if (s[b]) begin
          beat[b*8 +: 8] = d[b*8 +: 8];
        end
      end
      mem[a[31:3]] = beat;
    end
    stall();
    bvalid = 1'b1;
    bresp = a[31] ? resp_slverr : `RV_RESP_OKAY;
    @(posedge clock);
    assert (bready) else begin
      failures++;
      $display("bready low while bvalid was offered at %0t", $time);
    end
    #1 bvalid = 1'b0;
    bresp = `RV_RESP_OKAY;
  endtask

  // axi slave, one transaction at a time
  initial begin : axi_slave
    awready = 1'b0;
    wready = 1'b0;
    bvalid = 1'b0;
    bresp = `RV_RESP_OKAY;
    arready = 1'b0;
    rvalid = 1'b0;
    rdata = '0;
    rresp = `RV_RESP_OKAY;
    lfsr_state = 32'h0c53b83f;
    forever begin
      @(posedge clock);
      if (!reset && arvalid) begin
        #1;
        handle_read();
      end else if (!reset && (awvalid || wvalid)) begin
        #1;
        handle_write();
      end
    end
  end

  task automatic load_vectors();
    int fd;
    int n;
    string line;
    int p, w, pr, e;
    logic [31:0] a, wd, rd;
    logic [3:0] m;
    fd = $fopen("bench/rv32i_bus_vectors.txt", "r");
    if (fd == 0) begin
      failures++;
      $display("could not open bench/rv32i_bus_vectors.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%d %d %h %h %h %d %h %d", p, w, a, wd, m, pr, rd, e);
          if (n == 8) begin
            v_port.push_back(p);
            v_we.push_back(w != 0);
            v_addr.push_back(a);
            v_wdata.push_back(wd);
            v_mask.push_back(m);
            v_pair.push_back(pr != 0);
            v_rdata.push_back(rd);
            v_err.push_back(e != 0);
          end else begin
            failures++;
            $display("unreadable vector line: %s", line);
          end
        end
      end
      $fclose(fd);
    end
    cycle_limit = v_port.size() * 40 + 100;
  endtask

  task automatic drive_request(input int k);
    if (v_port[k] == 0) begin
      fetch_req = 1'b1;
      fetch_addr = v_addr[k];
    end else begin
      data_req = 1'b1;
      data_we = v_we[k];
      data_addr = v_addr[k];
      data_wdata = v_wdata[k];
      data_mask = v_mask[k];
    end
  endtask

  task automatic check_response(input int k, input word_t got_data, input logic got_err);
    if (!v_we[k]) begin
      assert (got_data === v_rdata[k]) else begin
        mismatches++;
        $display("Mismatch at %0t: vector %0d read %h, expected %h",
                 $time, k, got_data, v_rdata[k]);
      end
    end
    assert (got_err === v_err[k]) else begin
      mismatches++;
      $display("Mismatch at %0t: vector %0d err %b, expected %b", $time, k, got_err, v_err[k]);
    end
  endtask

  // fi and di are vector indexes, -1 when that port is idle
  task automatic wait_done(input int fi, input int di, output int first_port);
    int cycles;
    int limit;
    bit f_open;
    bit d_open;
    f_open = (fi >= 0);
    d_open = (di >= 0);
    limit = (f_open ? 40 : 0) + (d_open ? 40 : 0);
    first_port = -1;
    cycles = 0;
    while ((f_open || d_open) && cycles < limit) begin
      @(posedge clock);
      cycles++;
      assert (!(fetch_done && data_done)) else begin
        failures++;
        $display("both done outputs high in one cycle at %0t", $time);
      end
      if (fetch_done) begin
        assert (f_open) else begin
          failures++;
          $display("fetch done at %0t without an open request", $time);
        end
        if (f_open) begin
          check_response(fi, fetch_data, fetch_err);
          f_open = 1'b0;
          if (first_port < 0) first_port = 0;
        end
      end
      if (data_done) begin
        assert (d_open) else begin
          failures++;
          $display("data done at %0t without an open request", $time);
        end
        if (d_open) begin
          check_response(di, data_rdata, data_err);
          d_open = 1'b0;
          if (first_port < 0) first_port = 1;
        end
      end
    end
    if (f_open) begin
      failures++;
      $display("fetch request of vector %0d got no done within %0d cycles", fi, limit);
    end
    if (d_open) begin
      failures++;
      $display("data request of vector %0d got no done within %0d cycles", di, limit);
    end
  endtask

  task automatic run_vectors();
    int i;
    int fi;
    int di;
    int first_port;
    int last_port;
    bit paired;
    i = 0;
    last_port = -1;
    while (i < v_port.size()) begin
      paired = v_pair[i] && (i + 1 < v_port.size()) && (v_port[i] != v_port[i + 1]);
      if (v_pair[i] && !paired) begin
        failures++;
        $display("vector %0d cannot be paired with the next line", i);
      end
      // the edges between two transactions carry no done
      check_quiet(1);
      #1;
      drive_request(i);
      if (paired) drive_request(i + 1);
      check_quiet(1);
      #1;
      fetch_req = 1'b0;
      data_req = 1'b0;
      fi = (v_port[i] == 0) ? i : -1;
      di = (v_port[i] == 0) ? -1 : i;
      if (paired && v_port[i + 1] == 0) fi = i + 1;
      if (paired && v_port[i + 1] != 0) di = i + 1;
      wait_done(fi, di, first_port);
      if (paired) begin
        // a tie goes to the port not granted last
        if (last_port >= 0 && first_port >= 0) begin
          assert (first_port != last_port) else begin
            mismatches++;
            $display("Mismatch at %0t: tie at vector %0d granted to port %0d again",
                     $time, i, first_port);
          end
        end
        if (first_port >= 0) last_port = 1 - first_port;
        i += 2;
      end else begin
        last_port = v_port[i];
        i++;
      end
    end
  endtask

  task automatic check_quiet(input int cycles);
    repeat (cycles) begin
      @(posedge clock);
      assert (!awvalid && !wvalid && !arvalid && !bready && !rready &&
              !fetch_done && !data_done) else begin
        mismatches++;
        $display("Mismatch at %0t: AXI or done output high with no request", $time);
      end
    end
  endtask

  task automatic report_and_finish();
    $display("summary: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    failures++;
    $display("timeout: run stopped after %0d cycles", cycle_count);
    report_and_finish();
  end

  initial begin : sequencer
    reset = 1'b1;
    fetch_req = 1'b0;
    fetch_addr = '0;
    data_req = 1'b0;
    data_we = 1'b0;
    data_addr = '0;
    data_wdata = '0;
    data_mask = '0;
    load_vectors();
    repeat (2) @(posedge clock);
    #1 reset = 1'b0;
    check_quiet(3);
    if (v_port.size() > 0) run_vectors();
    // no stray done after the last vector
    check_quiet(5);
    report_and_finish();
  end

endmodule

//--- rv32i_bus.f
+incdir+verilog
verilog/rv32i_bus_pkg.sv
verilog/bus_req_if.sv
verilog/bus_port.sv
verilog/bus_arbiter.sv
verilog/axi_engine.sv
verilog/rv32i_bus.sv
bench/tb_rv32i_bus.sv

//--- bench/rv32i_bus_vectors.txt
# port(0 fetch, 1 data) we addr wdata mask pair exp_rdata exp_err, all but port/we/pair/err in hex
# pair 1 issues the line in the same cycle as the next; exp_rdata is ignored for writes
1 1 00000104 11223344 f 0 00000000 0
0 0 00000104 00000000 0 0 11223344 0
0 0 00000100 00000000 0 0 00000100 0
1 1 00000200 aabbccdd f 0 00000000 0
1 1 00000200 55667788 5 0 00000000 0
1 0 00000200 00000000 0 0 aa66cc88 0
1 1 0000020c 01020304 c 0 00000000 0
1 0 0000020c 00000000 0 0 0102020c 0
0 0 00000208 00000000 0 0 00000208 0
0 0 00000300 00000000 0 1 00000300 0
1 1 00000304 cafef00d f 0 00000000 0
1 0 00000304 00000000 0 0 cafef00d 0
1 0 00000400 00000000 0 1 00000400 0
0 0 00000408 00000000 0 0 00000408 0
0 0 00000304 00000000 0 1 cafef00d 0
1 1 00000500 deadbeef 3 0 00000000 0
1 0 00000500 00000000 0 0 0000beef 0
1 0 80000010 00000000 0 0 00000000 1
0 0 80000024 00000000 0 0 00000000 1
1 1 80000008 12345678 f 0 00000000 1
1 0 00000008 00000000 0 0 00000008 0
0 0 80000100 00000000 0 1 00000000 1
1 0 00000104 00000000 0 0 11223344 0
